/* compile.f */
verilog/wbuf_pkg.sv
verilog/mem_pkg.sv
verilog/rr_arbiter.sv
verilog/wbuf_store.sv
verilog/wbuf_tx_select.sv
verilog/wbuf_tx_tracker.sv
verilog/wbuf_top.sv
dv/tb_wbuf.sv

/* run.sh */
#!/bin/sh
# build the store buffer testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_wbuf -f compile.f -o sim_wbuf

./obj_dir/sim_wbuf > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

/* dv/tb_wbuf.sv */
// directed testbench for the coalescing store buffer
// a memory responder takes transfers and returns their IDs after a random delay
`timescale 1ns/10ps
`default_nettype none

module tb_wbuf import wbuf_pkg::*; import mem_pkg::*; ();

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int SEED           = 10;
  localparam int RTRN_DELAY_MAX = 4;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  req_i;
  logic [PADDR_W-1:0]    addr_i;
  logic [WORD_BYTES-1:0] be_i;
  logic [WORD_W-1:0]     wdata_i;
  logic                  gnt_o;
  logic                  mem_req_o;
  logic                  mem_ack_i = 1'b0;
  logic [PADDR_W-1:0]    mem_paddr_o;
  mem_size_e             mem_size_o;
  logic [WORD_W-1:0]     mem_wdata_o;
  logic [TX_ID_W-1:0]    mem_id_o;
  logic                  mem_rtrn_vld_i = 1'b0;
  logic [TX_ID_W-1:0]    mem_rtrn_id_i = '0;
  logic                  empty_o;

  // responder controls that change only on the falling edge
  bit ack_en = 1'b1;
  bit rtrn_en = 1'b1;

  // accepted transfers in order, and IDs still waiting for their return
  logic [PADDR_W-1:0] log_addr[$];
  mem_size_e          log_size[$];
  logic [WORD_W-1:0]  log_data[$];
  logic [TX_ID_W-1:0] pend_id[$];
  int                 pend_due[$];
  int                 resp_cycle = 0;
  int                 errors = 0;
  int                 cycles = 0;

  wbuf_top uut (
    .clk_i, .rst_ni, .req_i, .addr_i, .be_i, .wdata_i, .gnt_o,
    .mem_req_o, .mem_ack_i, .mem_paddr_o, .mem_size_o, .mem_wdata_o, .mem_id_o,
    .mem_rtrn_vld_i, .mem_rtrn_id_i, .empty_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // checks and reporting
  ////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_size(input string name, input mem_size_e act, input mem_size_e exp);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %s expected %s", $time, name, act.name(), exp.name());
    end
  endtask

  task automatic check_vec(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, act, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : p_responder
    int delay;
    if (rst_ni) begin
      // every ID unreturned means the slot table is full
      if (pend_id.size() >= MAX_TX && mem_req_o) begin
        report_error("memory request raised while every transaction ID is outstanding");
      end
      if (mem_req_o && mem_ack_i) begin
        if (pend_id.size() >= MAX_TX) begin
          report_error("more transactions accepted than there are IDs");
        end
        foreach (pend_id[i]) begin
          if (pend_id[i] == mem_id_o) begin
            report_error("transaction ID reused while still outstanding");
          end
        end
        log_addr.push_back(mem_paddr_o);
        log_size.push_back(mem_size_o);
        log_data.push_back(mem_wdata_o);
        delay = int'($urandom_range(RTRN_DELAY_MAX, 1));
        pend_id.push_back(mem_id_o);
        pend_due.push_back(resp_cycle + delay);
      end
    end
    mem_ack_i <= ack_en;
    // one return per cycle with the oldest first
    if (rtrn_en && pend_id.size() > 0 && pend_due[0] <= resp_cycle) begin
      mem_rtrn_vld_i <= 1'b1;
      mem_rtrn_id_i  <= pend_id.pop_front();
      void'(pend_due.pop_front());
    end else begin
      mem_rtrn_vld_i <= 1'b0;
    end
    resp_cycle++;
  end

  always @(posedge clk_i) begin : p_timeout
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d", errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // drivers and helpers
  ////////////////////////////////////////////////////////////

  task automatic set_resp(input bit ack, input bit rtrn);
    @(negedge clk_i);
    ack_en  = ack;
    rtrn_en = rtrn;
  endtask

  // stall counts the cycles spent waiting for the grant
  task automatic do_store(input logic [PADDR_W-1:0] addr, input logic [WORD_BYTES-1:0] be,
                          input logic [WORD_W-1:0] data, output int stall);
    stall = 0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= data;
    @(negedge clk_i);
    while (!gnt_o) begin
      stall++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
  endtask

  task automatic store_blocked(input logic [PADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                               input int n);
    @(posedge clk_i);
    req_i   <= 1'b1;
    addr_i  <= addr;
    be_i    <= '1;
    wdata_i <= data;
    repeat (n) begin
      @(negedge clk_i);
      check_flag("gnt_o", gnt_o, 1'b0);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
  endtask

  task automatic expect_xfer(input logic [PADDR_W-1:0] addr, input mem_size_e size,
                             input logic [WORD_W-1:0] data);
    @(negedge clk_i);
    while (log_addr.size() == 0) @(negedge clk_i);
    check_vec("mem_paddr_o", log_addr.pop_front(), addr);
    check_size("mem_size_o", log_size.pop_front(), size);
    check_vec("mem_wdata_o", log_data.pop_front(), data);
  endtask

  task automatic wait_empty();
    @(negedge clk_i);
    while (!empty_o) @(negedge clk_i);
  endtask

  task automatic expect_idle(input string what);
    if (log_addr.size() != 0) begin
      report_error($sformatf("unexpected transfer to %h during %s", log_addr[0], what));
      log_addr.delete();
      log_size.delete();
      log_data.delete();
    end
  endtask

  // every logged transfer must be a dword and one address is checked for data
  task automatic drain_dwords(input int exp_count, input logic [PADDR_W-1:0] watch_addr,
                              input logic [WORD_W-1:0] watch_data);
    int count;
    count = 0;
    while (log_addr.size() > 0) begin
      check_size("mem_size_o", log_size.pop_front(), SIZE_DWORD);
      if (log_addr[0] == watch_addr) begin
        check_vec("mem_wdata_o", log_data[0], watch_data);
      end
      void'(log_addr.pop_front());
      void'(log_data.pop_front());
      count++;
    end
    check_vec("transfer count", 64'(count), 64'(exp_count));
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_full_word();
    int stall;
    set_resp(1'b1, 1'b1);
    // offset bits of the store address are ignored
    do_store(32'h0000_1003, 8'hff, 64'h0123_4567_89ab_cdef, stall);
    expect_xfer(32'h0000_1000, SIZE_DWORD, 64'h0123_4567_89ab_cdef);
    check_flag("empty_o", empty_o, 1'b0);
    wait_empty();
    expect_idle("full word store");
  endtask

  task automatic test_coalesce();
    int stall;
    set_resp(1'b0, 1'b1);
    do_store(32'h0000_2000, 8'h0f, 64'h0000_0000_4433_2211, stall);
    do_store(32'h0000_2000, 8'hf0, 64'h8877_6655_0000_0000, stall);
    @(negedge clk_i);
    // the waiting offer already covers both stores
    check_flag("mem_req_o", mem_req_o, 1'b1);
    check_vec("mem_paddr_o", mem_paddr_o, 32'h0000_2000);
    check_size("mem_size_o", mem_size_o, SIZE_DWORD);
    set_resp(1'b1, 1'b1);
    expect_xfer(32'h0000_2000, SIZE_DWORD, 64'h8877_6655_4433_2211);
    wait_empty();
    expect_idle("coalescing");
  endtask

  task automatic test_split();
    int stall;
    set_resp(1'b1, 1'b1);
    // bytes 0, 3, 4 and 5 dirty
    do_store(32'h0000_3000, 8'h39, 64'h8877_6655_4433_2211, stall);
    expect_xfer(32'h0000_3000, SIZE_BYTE, 64'h1111_1111_1111_1111);
    expect_xfer(32'h0000_3003, SIZE_BYTE, 64'h4444_4444_4444_4444);
    expect_xfer(32'h0000_3004, SIZE_HALF, 64'h6655_6655_6655_6655);
    wait_empty();
    expect_idle("split mask");
  endtask

  task automatic test_rewrite();
    int stall;
    set_resp(1'b1, 1'b0);
    do_store(32'h0000_4000, 8'hff, 64'ha7a6_a5a4_a3a2_a1a0, stall);
    expect_xfer(32'h0000_4000, SIZE_DWORD, 64'ha7a6_a5a4_a3a2_a1a0);
    // byte 2 rewritten while the dword is in flight
    do_store(32'h0000_4002, 8'h04, 64'h0000_0000_005c_0000, stall);
    check_flag("gnt_o on in-flight hit", stall == 0, 1'b1);
    repeat (6) begin
      @(negedge clk_i);
      check_flag("mem_req_o", mem_req_o, 1'b0);
    end
    expect_idle("rewrite while in flight");
    set_resp(1'b1, 1'b1);
    expect_xfer(32'h0000_4002, SIZE_BYTE, 64'h5c5c_5c5c_5c5c_5c5c);
    check_flag("empty_o", empty_o, 1'b0);
    wait_empty();
    expect_idle("rewrite after return");
  endtask

  task automatic test_full_buffer();
    int stall;
    set_resp(1'b1, 1'b0);
    for (int k = 0; k < WBUF_DEPTH; k++) begin
      do_store(32'h0000_5000 + PADDR_W'(k * WORD_BYTES), 8'hff, {8{8'(8'h50 + k)}}, stall);
    end
    store_blocked(32'h0000_5020, {8{8'h5f}}, 8);
    // a hit still merges into the full store
    do_store(32'h0000_5010, 8'h01, 64'h0000_0000_0000_00e2, stall);
    check_flag("gnt_o on hit to full buffer", stall == 0, 1'b1);
    set_resp(1'b1, 1'b1);
    do_store(32'h0000_5020, 8'hff, {8{8'h5f}}, stall);
    wait_empty();
    drain_dwords(WBUF_DEPTH + 1, 32'h0000_5010, 64'h5252_5252_5252_52e2);
  endtask

  task automatic test_tx_limit();
    int stall;
    set_resp(1'b1, 1'b0);
    for (int k = 0; k < MAX_TX + 1; k++) begin
      do_store(32'h0000_6000 + PADDR_W'(k * WORD_BYTES), 8'hff, {8{8'(8'h60 + k)}}, stall);
    end
    @(negedge clk_i);
    while (pend_id.size() < MAX_TX) @(negedge clk_i);
    repeat (6) begin
      @(negedge clk_i);
      check_flag("mem_req_o", mem_req_o, 1'b0);
    end
    for (int i = 0; i < MAX_TX; i++) begin
      for (int j = i + 1; j < MAX_TX; j++) begin
        check_flag("outstanding IDs distinct", pend_id[i] != pend_id[j], 1'b1);
      end
    end
    set_resp(1'b1, 1'b1);
    wait_empty();
    drain_dwords(MAX_TX + 1, 32'h0000_6010, {8{8'h62}});
  endtask

  initial begin : p_main
    void'($urandom(SEED));
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    addr_i  = '0;
    be_i    = '0;
    wdata_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("mem_req_o", mem_req_o, 1'b0);
    check_flag("gnt_o", gnt_o, 1'b0);
    test_full_word();
    test_coalesce();
    test_split();
    test_rewrite();
    test_full_buffer();
    test_tx_limit();
    repeat (4) @(posedge clk_i);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/wbuf_top.sv */
// coalescing store write buffer between a core store port and a memory write channel
// connects the entry store, the transfer select and the transaction tracker
`timescale 1ns/10ps
`default_nettype none

module wbuf_top import wbuf_pkg::*; import mem_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // store port
  input  logic                  req_i,
  input  logic [PADDR_W-1:0]    addr_i,
  input  logic [WORD_BYTES-1:0] be_i,
  input  logic [WORD_W-1:0]     wdata_i,
  output logic                  gnt_o,
  // memory write channel
  output logic                  mem_req_o,
  input  logic                  mem_ack_i,
  output logic [PADDR_W-1:0]    mem_paddr_o,
  output mem_size_e             mem_size_o,
  output logic [WORD_W-1:0]     mem_wdata_o,
  output logic [TX_ID_W-1:0]    mem_id_o,
  // write acknowledge
  input  logic                  mem_rtrn_vld_i,
  input  logic [TX_ID_W-1:0]    mem_rtrn_id_i,
  output logic                  empty_o
);

  logic [WBUF_DEPTH-1:0][WORD_BYTES-1:0] dirty_rdy;
  logic [WBUF_DEPTH-1:0][WTAG_W-1:0]     wtag;
  logic [WBUF_DEPTH-1:0][WORD_W-1:0]     data;
  logic                                  slot_free;
  logic                                  send;
  logic [WBUF_PTR_W-1:0]                 send_ptr;
  logic [WORD_BYTES-1:0]                 send_be;
  logic                                  evict;
  logic [WBUF_PTR_W-1:0]                 evict_ptr;
  logic [WORD_BYTES-1:0]                 evict_be;

  wbuf_store i_store (
    .clk_i, .rst_ni, .req_i, .addr_i, .be_i, .wdata_i, .gnt_o,
    .send_i      ( send      ),
    .send_ptr_i  ( send_ptr  ),
    .send_be_i   ( send_be   ),
    .evict_i     ( evict     ),
    .evict_ptr_i ( evict_ptr ),
    .evict_be_i  ( evict_be  ),
    .dirty_rdy_o ( dirty_rdy ),
    .wtag_o      ( wtag      ),
    .data_o      ( data      ),
    .empty_o
  );

  wbuf_tx_select i_tx_select (
    .clk_i, .rst_ni,
    .dirty_rdy_i ( dirty_rdy ),
    .wtag_i      ( wtag      ),
    .data_i      ( data      ),
    .slot_free_i ( slot_free ),
    .mem_ack_i, .mem_req_o, .mem_paddr_o, .mem_size_o, .mem_wdata_o,
    .send_o      ( send      ),
    .send_ptr_o  ( send_ptr  ),
    .send_be_o   ( send_be   )
  );

  wbuf_tx_tracker i_tx_tracker (
    .clk_i, .rst_ni,
    .send_i      ( send      ),
    .send_ptr_i  ( send_ptr  ),
    .send_be_i   ( send_be   ),
    .mem_rtrn_vld_i, .mem_rtrn_id_i, .mem_id_o,
    .slot_free_o ( slot_free ),
    .evict_o     ( evict     ),
    .evict_ptr_o ( evict_ptr ),
    .evict_be_o  ( evict_be  )
  );

endmodule

`default_nettype wire

/* verilog/wbuf_tx_tracker.sv */
// outstanding write transactions: one slot per ID with entry pointer and byte mask
// returned IDs are queued and popped one per cycle as evictions
`timescale 1ns/10ps
`default_nettype none

module wbuf_tx_tracker import wbuf_pkg::*; import mem_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // accepted transfer
  input  logic                  send_i,
  input  logic [WBUF_PTR_W-1:0] send_ptr_i,
  input  logic [WORD_BYTES-1:0] send_be_i,
  // return strobe, no back-pressure
  input  logic                  mem_rtrn_vld_i,
  input  logic [TX_ID_W-1:0]    mem_rtrn_id_i,
  output logic [TX_ID_W-1:0]    mem_id_o,
  output logic                  slot_free_o,
  // eviction towards the store
  output logic                  evict_o,
  output logic [WBUF_PTR_W-1:0] evict_ptr_o,
  output logic [WORD_BYTES-1:0] evict_be_o
);

  logic [MAX_TX-1:0]                 slot_vld_q;
  logic [MAX_TX-1:0][WBUF_PTR_W-1:0] slot_ptr_q;
  logic [MAX_TX-1:0][WORD_BYTES-1:0] slot_be_q;

  // return queue, depth MAX_TX
  logic [MAX_TX-1:0][TX_ID_W-1:0] q_mem;
  logic [TX_ID_W-1:0]             q_wr_q, q_rd_q;
  logic [TX_ID_W:0]               q_cnt_q;
  logic [TX_ID_W-1:0]             rtrn_id;

  // next free ID
  rr_arbiter #(
    .NUM_IN  ( MAX_TX      ),
    .LOCK_IN ( 1'b1        )
  ) i_id_arb (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .req_i   ( ~slot_vld_q ),
    .gnt_i   ( send_i      ),
    .idx_o   ( mem_id_o    ),
    .valid_o ( slot_free_o )
  );

  ////////////////////////////////////////////////////////////
  // return queue
  ////////////////////////////////////////////////////////////

  // registered head, so a strobe evicts one cycle later at the earliest
  assign evict_o     = (q_cnt_q != '0);
  assign rtrn_id     = q_mem[q_rd_q];
  assign evict_ptr_o = slot_ptr_q[rtrn_id];
  assign evict_be_o  = slot_be_q[rtrn_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_queue
    if (!rst_ni) begin
      q_wr_q  <= '0;
      q_rd_q  <= '0;
      q_cnt_q <= '0;
    end else begin
      if (mem_rtrn_vld_i) begin
        q_wr_q <= q_wr_q + 1'b1;
      end
      if (evict_o) begin
        q_rd_q <= q_rd_q + 1'b1;
      end
      q_cnt_q <= q_cnt_q + (TX_ID_W + 1)'(mem_rtrn_vld_i) - (TX_ID_W + 1)'(evict_o);
    end
  end

  always_ff @(posedge clk_i) begin : p_queue_mem
    if (mem_rtrn_vld_i) begin
      q_mem[q_wr_q] <= mem_rtrn_id_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // slot table
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_slot_vld
    if (!rst_ni) begin
      slot_vld_q <= '0;
    end else begin
      // evicted and allocated IDs never coincide, a free ID is never evicted
      if (evict_o) begin
        slot_vld_q[rtrn_id] <= 1'b0;
      end
      if (send_i) begin
        slot_vld_q[mem_id_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot_data
    if (send_i) begin
      slot_ptr_q[mem_id_o] <= send_ptr_i;
      slot_be_q[mem_id_o]  <= send_be_i;
    end
  end

  a_evict_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evict_o |-> slot_vld_q[rtrn_id])
    else $error("eviction of a transaction that is not outstanding");

  // each outstanding ID returns once, so queued IDs stay within the slots
  a_queue_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(q_cnt_q) <= $countones(slot_vld_q))
    else $error("return queue holds more IDs than outstanding transactions");

endmodule

`default_nettype wire

/* verilog/wbuf_tx_select.sv */
// picks a dirty entry and forms one aligned memory transfer from it
// non-contiguous dirty bytes leave as several transfers
`timescale 1ns/10ps
`default_nettype none

module wbuf_tx_select import wbuf_pkg::*; import mem_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [WBUF_DEPTH-1:0][WORD_BYTES-1:0] dirty_rdy_i,
  input  logic [WBUF_DEPTH-1:0][WTAG_W-1:0]     wtag_i,
  input  logic [WBUF_DEPTH-1:0][WORD_W-1:0]     data_i,
  input  logic                                  slot_free_i,
  input  logic                                  mem_ack_i,
  output logic                                  mem_req_o,
  output logic [PADDR_W-1:0]                    mem_paddr_o,
  output mem_size_e                             mem_size_o,
  output logic [WORD_W-1:0]                     mem_wdata_o,
  output logic                                  send_o,
  output logic [WBUF_PTR_W-1:0]                 send_ptr_o,
  output logic [WORD_BYTES-1:0]                 send_be_o
);

  logic [WBUF_DEPTH-1:0] dirty_any;
  logic                  arb_vld;
  logic [WORD_BYTES-1:0] sel_dirty;
  logic [WORD_BYTES-1:0] dirty_sh;
  logic [BYTE_OFF_W-1:0] sel_off;
  logic [WORD_W-1:0]     data_sh;

  for (genvar k = 0; k < WBUF_DEPTH; k++) begin : gen_any
    assign dirty_any[k] = |dirty_rdy_i[k];
  end

  // lock-in keeps the offered transfer stable until it is acked
  rr_arbiter #(
    .NUM_IN  ( WBUF_DEPTH ),
    .LOCK_IN ( 1'b1       )
  ) i_entry_arb (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( dirty_any  ),
    .gnt_i   ( send_o     ),
    .idx_o   ( send_ptr_o ),
    .valid_o ( arb_vld    )
  );

  assign sel_dirty = dirty_rdy_i[send_ptr_o];

  // lowest dirty byte offset
  always_comb begin : p_off
    sel_off = '0;
    for (int j = WORD_BYTES - 1; j >= 0; j--) begin
      if (sel_dirty[j]) begin
        sel_off = BYTE_OFF_W'(j);
      end
    end
  end

  // dirty run starting at the offset, used for the size choice
  assign dirty_sh = sel_dirty >> sel_off;

  // widest aligned size that is fully dirty
  always_comb begin : p_size
    if (&sel_dirty) begin
      mem_size_o = SIZE_DWORD;
    end else if (sel_off[1:0] == 2'b00 && &dirty_sh[3:0]) begin
      mem_size_o = SIZE_WORD;
    end else if (!sel_off[0] && &dirty_sh[1:0]) begin
      mem_size_o = SIZE_HALF;
    end else begin
      mem_size_o = SIZE_BYTE;
    end
  end

  // addressed bytes moved down, then replicated over the bus
  assign data_sh = data_i[send_ptr_o] >> {sel_off, 3'b000};

  always_comb begin : p_lane
    unique case (mem_size_o)
      SIZE_BYTE: begin
        send_be_o   = WORD_BYTES'(8'h01) << sel_off;
        mem_wdata_o = {8{data_sh[7:0]}};
      end
      SIZE_HALF: begin
        send_be_o   = WORD_BYTES'(8'h03) << sel_off;
        mem_wdata_o = {4{data_sh[15:0]}};
      end
      SIZE_WORD: begin
        send_be_o   = WORD_BYTES'(8'h0f) << sel_off;
        mem_wdata_o = {2{data_sh[31:0]}};
      end
      default: begin
        send_be_o   = '1;
        mem_wdata_o = data_i[send_ptr_o];
      end
    endcase
  end

  assign mem_paddr_o = {wtag_i[send_ptr_o], sel_off};
  // no request without a free transaction ID
  assign mem_req_o   = arb_vld & slot_free_i;
  assign send_o      = mem_req_o & mem_ack_i;

endmodule

`default_nettype wire

/* verilog/wbuf_store.sv */
// entry array of the store buffer with per-byte valid, dirty and in-flight flags
// merges stores to the same word and applies send and eviction updates
`timescale 1ns/10ps
`default_nettype none

module wbuf_store import wbuf_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // store port
  input  logic                                  req_i,
  input  logic [PADDR_W-1:0]                    addr_i,
  input  logic [WORD_BYTES-1:0]                 be_i,
  input  logic [WORD_W-1:0]                     wdata_i,
  output logic                                  gnt_o,
  // bytes handed to memory
  input  logic                                  send_i,
  input  logic [WBUF_PTR_W-1:0]                 send_ptr_i,
  input  logic [WORD_BYTES-1:0]                 send_be_i,
  // acknowledged bytes
  input  logic                                  evict_i,
  input  logic [WBUF_PTR_W-1:0]                 evict_ptr_i,
  input  logic [WORD_BYTES-1:0]                 evict_be_i,
  // entry view for the transfer select
  output logic [WBUF_DEPTH-1:0][WORD_BYTES-1:0] dirty_rdy_o,
  output logic [WBUF_DEPTH-1:0][WTAG_W-1:0]     wtag_o,
  output logic [WBUF_DEPTH-1:0][WORD_W-1:0]     data_o,
  output logic                                  empty_o
);

  logic [WBUF_DEPTH-1:0][WTAG_W-1:0]     wtag_q;
  logic [WBUF_DEPTH-1:0][WORD_W-1:0]     data_q;
  logic [WBUF_DEPTH-1:0][WORD_BYTES-1:0] valid_q, valid_d;
  logic [WBUF_DEPTH-1:0][WORD_BYTES-1:0] dirty_q, dirty_d;
  logic [WBUF_DEPTH-1:0][WORD_BYTES-1:0] infl_q, infl_d;

  logic [WBUF_DEPTH-1:0] used;
  logic [WBUF_DEPTH-1:0] hit_oh;
  logic [WTAG_W-1:0]     req_wtag;
  logic [WBUF_PTR_W-1:0] hit_ptr, free_ptr, wr_ptr;
  logic                  full;
  logic                  wr_en;

  ////////////////////////////////////////////////////////////
  // lookup and allocation
  ////////////////////////////////////////////////////////////

  // low offset bits do not take part in the match
  assign req_wtag = addr_i[PADDR_W-1:BYTE_OFF_W];

  for (genvar k = 0; k < WBUF_DEPTH; k++) begin : gen_entry
    assign used[k]   = |valid_q[k];
    assign hit_oh[k] = used[k] && (wtag_q[k] == req_wtag);
    // an entry with a byte in flight sends nothing until the ack
    assign dirty_rdy_o[k] = (|infl_q[k]) ? '0 : (dirty_q[k] & valid_q[k]);
  end

  // hit index and lowest free entry
  always_comb begin : p_ptrs
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = WBUF_PTR_W'(k);
      end
      if (!used[k]) begin
        free_ptr = WBUF_PTR_W'(k);
      end
    end
  end

  assign full    = &used;
  assign gnt_o   = req_i && ((|hit_oh) || !full);
  assign wr_en   = gnt_o;
  assign wr_ptr  = (|hit_oh) ? hit_ptr : free_ptr;
  assign empty_o = ~|used;
  assign wtag_o  = wtag_q;
  assign data_o  = data_q;

  ////////////////////////////////////////////////////////////
  // byte state updates
  ////////////////////////////////////////////////////////////

  // order matters: eviction, then send, then the new store on top
  always_comb begin : p_state
    valid_d = valid_q;
    dirty_d = dirty_q;
    infl_d  = infl_q;
    if (evict_i) begin
      // bytes rewritten meanwhile stay valid for another send
      infl_d[evict_ptr_i]  = infl_q[evict_ptr_i] & ~evict_be_i;
      valid_d[evict_ptr_i] = valid_q[evict_ptr_i] & ~(evict_be_i & ~dirty_q[evict_ptr_i]);
    end
    if (send_i) begin
      dirty_d[send_ptr_i] = dirty_d[send_ptr_i] & ~send_be_i;
      infl_d[send_ptr_i]  = infl_d[send_ptr_i] | send_be_i;
    end
    if (wr_en) begin
      valid_d[wr_ptr] = valid_d[wr_ptr] | be_i;
      dirty_d[wr_ptr] = dirty_d[wr_ptr] | be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_flags
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      infl_q  <= '0;
    end else begin
      valid_q <= valid_d;
      dirty_q <= dirty_d;
      infl_q  <= infl_d;
    end
  end

  // tag and data payload, merged byte by byte
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en) begin
      wtag_q[wr_ptr] <= req_wtag;
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (be_i[j]) begin
          data_q[wr_ptr][j*8 +: 8] <= wdata_i[j*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> $onehot0(hit_oh))
    else $error("store word matches more than one entry");

  a_evict_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evict_i |-> used[evict_ptr_i])
    else $error("eviction of an empty entry");

  // legal states are free, dirty, in flight, and rewritten in flight
  for (genvar k = 0; k < WBUF_DEPTH; k++) begin : gen_chk_entry
    for (genvar j = 0; j < WORD_BYTES; j++) begin : gen_chk_byte
      a_byte_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        {valid_q[k][j], dirty_q[k][j], infl_q[k][j]} inside {3'b000, 3'b110, 3'b101, 3'b111})
        else $error("entry %0d byte %0d in illegal state", k, j);
    end
  end

endmodule

`default_nettype wire

/* verilog/rr_arbiter.sv */
// round-robin arbiter reporting the index of the chosen requester
// with LOCK_IN set the choice is held until it is granted
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
  parameter int NUM_IN  = 4,
  parameter bit LOCK_IN = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [NUM_IN-1:0]         req_i,
  input  logic                      gnt_i,
  output logic [$clog2(NUM_IN)-1:0] idx_o,
  output logic                      valid_o
);

  localparam int IDX_W = $clog2(NUM_IN);

  logic [IDX_W-1:0] prio_q;
  logic [IDX_W-1:0] pick_idx;
  logic             pick_vld;
  logic             lock_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic             use_lock;

  // search from the priority pointer upwards, wrapping around
  // walking downwards lets the closest requester win
  always_comb begin : p_pick
    logic [IDX_W-1:0] cand;
    pick_idx = prio_q;
    pick_vld = 1'b0;
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      cand = IDX_W'((int'(prio_q) + i) % NUM_IN);
      if (req_i[cand]) begin
        pick_idx = cand;
        pick_vld = 1'b1;
      end
    end
  end

  // a locked choice stays only while its requester still asks
  assign use_lock = LOCK_IN && lock_q && req_i[lock_idx_q];
  assign idx_o    = use_lock ? lock_idx_q : pick_idx;
  assign valid_o  = use_lock | pick_vld;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // offered but not yet taken
      lock_q     <= valid_o & ~gnt_i;
      lock_idx_q <= idx_o;
      // move priority just past the granted requester
      if (gnt_i) begin
        prio_q <= IDX_W'((int'(idx_o) + 1) % NUM_IN);
      end
    end
  end

  a_idx_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> req_i[idx_o])
    else $error("arbiter index points at an idle requester");

endmodule

`default_nettype wire

/* verilog/mem_pkg.sv */
// memory write channel definitions
// transfer size encoding and transaction ID space
`default_nettype none

package mem_pkg;

  // number of write transactions that may be outstanding at once
  localparam int MAX_TX  = 2;
  localparam int TX_ID_W = 1;

  // aligned transfer size on the memory bus
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HALF  = 2'd1,
    SIZE_WORD  = 2'd2,
    SIZE_DWORD = 2'd3
  } mem_size_e;

endpackage

`default_nettype wire

/* verilog/wbuf_pkg.sv */
// geometry of the coalescing store buffer
// imported by the store, the transfer select, the tracker and the top level
`default_nettype none

package wbuf_pkg;

  // entry count and entry index width
  localparam int WBUF_DEPTH = 4;
  localparam int WBUF_PTR_W = 2;

  // one entry holds one aligned 64-bit word
  localparam int WORD_BYTES = 8;
  localparam int WORD_W     = 64;
  localparam int BYTE_OFF_W = 3;

  // physical address split into word tag and byte offset
  localparam int PADDR_W = 32;
  localparam int WTAG_W  = PADDR_W - BYTE_OFF_W;

endpackage

`default_nettype wire
